//--- Makefile
VERILATOR ?= verilator
TOP       ?= udp_ip_tx_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard include/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- compile.f
+incdir+include
verilog/udp_tx_pkg.sv
verilog/pipe_skid_buffer.sv
verilog/udp_hdr_regs.sv
verilog/udp_payload_framer.sv
verilog/udp_ip_tx.sv
verification/udp_tx_scoreboard.sv
verification/udp_ip_tx_tb.sv

//--- include/udp_tx_defs.svh
// ----------------------------------------------------------
// constants for the UDP transmit framer
// the datapath assumes the UDP header fills exactly half a beat
// ----------------------------------------------------------
`ifndef UDP_TX_DEFS_SVH
`define UDP_TX_DEFS_SVH

// bytes per datapath beat
`define UDP_TX_DATA_BYTES 16

// fixed UDP header size
`define UDP_TX_UDP_HDR_BYTES 8

// IPv4 header without options
`define UDP_TX_IP_HDR_BYTES 20

// RoCEv2 ICRC appended later in the stack
`define UDP_TX_ICRC_BYTES 4

// RoCEv2 well known destination port
`define UDP_TX_ROCE_PORT 4791

`endif

//--- verification/udp_ip_tx_tb.sv
// ----------------------------------------------------------
// random frames, first without and then with output back-pressure
// payload tuser is always driven low
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "udp_tx_defs.svh"

module udp_ip_tx_tb;
  import udp_tx_pkg::*;

  localparam int  NUM_FRAMES   = 24;
  localparam int  RESET_CYCLES = 8;
  localparam int  MAX_LEN      = 80;
  localparam time WATCHDOG_NS  = (NUM_FRAMES * 200 + RESET_CYCLES) * 8;

  logic        clk;
  logic        rst;
  logic        s_hdr_valid, s_hdr_ready;
  logic [15:0] s_ip_identification;
  logic [7:0]  s_ip_ttl, s_ip_protocol;
  ip_addr_t    s_ip_source_ip, s_ip_dest_ip;
  len_t        s_udp_source_port, s_udp_dest_port, s_udp_length, s_udp_checksum;
  data_t       s_payload_tdata;
  keep_t       s_payload_tkeep;
  logic        s_payload_tvalid, s_payload_tready, s_payload_tlast, s_payload_tuser;
  logic        m_hdr_valid;
  logic        m_hdr_ready = 1'b0;
  len_t        m_ip_length;
  logic [15:0] m_ip_identification;
  logic [7:0]  m_ip_ttl, m_ip_protocol;
  ip_addr_t    m_ip_source_ip, m_ip_dest_ip;
  logic        m_is_roce;
  data_t       m_payload_tdata;
  keep_t       m_payload_tkeep;
  logic        m_payload_tvalid;
  logic        m_payload_tready = 1'b0;
  logic        m_payload_tlast, m_payload_tuser;
  logic        busy, error_early_term;
  logic [15:0] lfsr_state = 16'd38;
  logic        bp_phase = 1'b0;
  int          tb_errors = 0;
  int          idle_errors = 0;
  int          early_frames = 0;

  udp_ip_tx dut0 (.*);

  udp_tx_scoreboard sb0 (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all frames came out");
    $display("Simulation failed");
    $finish;
  end

  // x^16 + x^14 + x^13 + x^11, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
      lfsr_state = {lfsr_state[14:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  always @(posedge clk) begin
    if (bp_phase) begin
      m_payload_tready <= (rand_bits(2) != 0);
      m_hdr_ready      <= (rand_bits(1) != 0);
    end else begin
      m_payload_tready <= 1'b1;
      m_hdr_ready      <= 1'b1;
    end
  end

  task automatic run_frame(input int idx);
    logic [15:0]          dport, ulen;
    logic [MAX_LEN*8-1:0] pay;
    logic [127:0]         data;
    logic                 early;
    int                   len, extra, nbeats, n, errs_before, pulses_before;
    dport = (rand_bits(2) == 0) ? 16'(`UDP_TX_ROCE_PORT) : 16'(rand_bits(16));
    len   = 1 + int'(rand_bits(7)) % MAX_LEN;
    early = (rand_bits(8) % 6 == 0);
    extra = early ? 1 + int'(rand_bits(4)) : 0;
    ulen  = 16'(8 + len + extra);
    pay   = '0;
    for (int i = 0; i < len; i++) begin
      pay[i*8 +: 8] = 8'(rand_bits(8));
    end
    errs_before   = tb_errors + sb0.errors;
    pulses_before = sb0.early_pulses;
    s_ip_identification <= 16'(rand_bits(16));
    s_ip_ttl            <= 8'(rand_bits(8));
    s_ip_protocol       <= 8'(rand_bits(8));
    s_ip_source_ip      <= rand_bits(32);
    s_ip_dest_ip        <= rand_bits(32);
    s_udp_source_port   <= 16'(rand_bits(16));
    s_udp_checksum      <= 16'(rand_bits(16));
    s_udp_dest_port     <= dport;
    s_udp_length        <= ulen;
    s_hdr_valid         <= 1'b1;
    do @(posedge clk); while (!s_hdr_ready);
    s_hdr_valid <= 1'b0;
    sb0.add_frame(s_ip_identification, s_ip_ttl, s_ip_protocol, s_ip_source_ip,
                  s_ip_dest_ip, s_udp_source_port, dport, ulen, s_udp_checksum, pay, len);
    @(posedge clk);
    assert (busy) else begin
      $display("busy stayed low after header accept at %0t", $time);
      tb_errors++;
    end
    nbeats = (len + 15) / 16;
    for (int b = 0; b < nbeats; b++) begin
      if (rand_bits(2) == 0) begin
        s_payload_tvalid <= 1'b0;
        @(posedge clk);
      end
      n    = (len - b * 16 > 16) ? 16 : len - b * 16;
      data = '0;
      for (int i = 0; i < n; i++) begin
        data[i*8 +: 8] = pay[(b * 16 + i) * 8 +: 8];
      end
      s_payload_tdata  <= data;
      s_payload_tkeep  <= (n == 16) ? 16'hffff : 16'((32'd1 << n) - 32'd1);
      s_payload_tlast  <= (b == nbeats - 1);
      s_payload_tvalid <= 1'b1;
      do @(posedge clk); while (!s_payload_tready);
    end
    s_payload_tvalid <= 1'b0;
    s_payload_tlast  <= 1'b0;
    while (sb0.frame_count < idx + 1) @(posedge clk);
    @(posedge clk);
    if (early) early_frames++;
    assert (sb0.early_pulses == pulses_before + (early ? 1 : 0)) else begin
      $display("error_early_term pulse count wrong for frame %0d", idx);
      tb_errors++;
    end
    $display("frame %0d len %0d roce %0b early %0b bp %0b: %s", idx, len,
             dport == 16'(`UDP_TX_ROCE_PORT), early, bp_phase,
             (tb_errors + sb0.errors == errs_before) ? "ok" : "FAIL");
  endtask

  initial begin
    rst                 = 1'b1;
    s_hdr_valid         = 1'b0;
    s_ip_identification = '0;
    s_ip_ttl            = '0;
    s_ip_protocol       = '0;
    s_ip_source_ip      = '0;
    s_ip_dest_ip        = '0;
    s_udp_source_port   = '0;
    s_udp_dest_port     = '0;
    s_udp_length        = '0;
    s_udp_checksum      = '0;
    s_payload_tdata     = '0;
    s_payload_tkeep     = '0;
    s_payload_tvalid    = 1'b0;
    s_payload_tlast     = 1'b0;
    s_payload_tuser     = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(posedge clk);
    assert (!m_hdr_valid && !m_payload_tvalid && !busy && !error_early_term) else begin
      $display("outputs not idle after reset");
      tb_errors++;
    end
    $display("reset test: %s", (tb_errors == 0) ? "ok" : "FAIL");
    for (int i = 0; i < NUM_FRAMES / 2; i++) begin
      run_frame(i);
    end
    bp_phase <= 1'b1;
    for (int i = NUM_FRAMES / 2; i < NUM_FRAMES; i++) begin
      run_frame(i);
    end
    repeat (10) @(posedge clk);
    idle_errors = tb_errors;
    assert (!busy && sb0.frame_count == NUM_FRAMES && sb0.hdr_count == NUM_FRAMES &&
            sb0.early_pulses == early_frames)
    else begin
      $display("run did not end idle with all frames, headers and early pulses counted");
      tb_errors++;
    end
    $display("idle test: %s", (tb_errors == idle_errors) ? "ok" : "FAIL");
    $display("frames %0d of %0d, early %0d, errors %0d", sb0.frame_count, NUM_FRAMES,
             early_frames, tb_errors + sb0.errors);
    if (tb_errors + sb0.errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verification/udp_tx_scoreboard.sv
// ----------------------------------------------------------
// reference model for the UDP transmit framer, checks both outputs
// frames must be added in the order their headers are sent
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "udp_tx_defs.svh"

module udp_tx_scoreboard (
  input logic                 clk,
  input logic                 rst,
  input logic                 m_hdr_valid,
  input logic                 m_hdr_ready,
  input udp_tx_pkg::len_t     m_ip_length,
  input logic [15:0]          m_ip_identification,
  input logic [7:0]           m_ip_ttl,
  input logic [7:0]           m_ip_protocol,
  input udp_tx_pkg::ip_addr_t m_ip_source_ip,
  input udp_tx_pkg::ip_addr_t m_ip_dest_ip,
  input logic                 m_is_roce,
  input udp_tx_pkg::data_t    m_payload_tdata,
  input udp_tx_pkg::keep_t    m_payload_tkeep,
  input logic                 m_payload_tvalid,
  input logic                 m_payload_tready,
  input logic                 m_payload_tlast,
  input logic                 m_payload_tuser,
  input logic                 error_early_term
);
  import udp_tx_pkg::*;

  ip_hdr_t    exp_hdr[$];
  logic [7:0] exp_bytes[$];
  int         exp_len[$];
  logic       exp_user[$];
  int         errors = 0;
  int         frame_count = 0;
  int         hdr_count = 0;
  int         early_pulses = 0;
  int         remaining = 0;
  logic       cur_user = 1'b0;
  logic       prev_err = 1'b0;

  function automatic void compare_field(input string name, input logic [31:0] exp,
                                        input logic [31:0] act);
    assert (exp === act) else begin
      $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
    end
  endfunction

  // expected header and byte stream of one frame
  function automatic void add_frame(input logic [15:0] ident, input logic [7:0] ttl,
                                    input logic [7:0] proto, input logic [31:0] src,
                                    input logic [31:0] dst, input logic [15:0] sport,
                                    input logic [15:0] dport, input logic [15:0] ulen,
                                    input logic [15:0] csum, input logic [80*8-1:0] pay,
                                    input int len);
    ip_hdr_t     h;
    logic        roce;
    logic [15:0] len_field;
    roce      = (dport == 16'(`UDP_TX_ROCE_PORT));
    len_field = roce ? ulen + 16'(`UDP_TX_ICRC_BYTES) : ulen;
    h.ip_length      = ulen + 16'(`UDP_TX_IP_HDR_BYTES);
    h.identification = ident;
    h.ttl            = ttl;
    h.protocol       = proto;
    h.source_ip      = src;
    h.dest_ip        = dst;
    h.is_roce        = roce;
    exp_hdr.push_back(h);
    // UDP header in network byte order
    exp_bytes.push_back(sport[15:8]);
    exp_bytes.push_back(sport[7:0]);
    exp_bytes.push_back(dport[15:8]);
    exp_bytes.push_back(dport[7:0]);
    exp_bytes.push_back(len_field[15:8]);
    exp_bytes.push_back(len_field[7:0]);
    exp_bytes.push_back(csum[15:8]);
    exp_bytes.push_back(csum[7:0]);
    for (int i = 0; i < len; i++) begin
      exp_bytes.push_back(pay[i*8 +: 8]);
    end
    exp_len.push_back(8 + len);
    exp_user.push_back(len < int'(ulen) - 8);
  endfunction

  always @(posedge clk) begin
    ip_hdr_t    h;
    int         n;
    logic [7:0] b;
    if (!rst) begin
      if (error_early_term) begin
        assert (!prev_err) else begin
          $display("error_early_term stayed high for two cycles at %0t", $time);
          errors++;
        end
        early_pulses++;
      end
      prev_err = error_early_term;
      if (m_hdr_valid && m_hdr_ready) begin
        hdr_count++;
        assert (exp_hdr.size() > 0) else begin
          $display("header came out with no frame pending at %0t", $time);
          errors++;
        end
        if (exp_hdr.size() > 0) begin
          h = exp_hdr.pop_front();
          compare_field("m_ip_length", h.ip_length, m_ip_length);
          compare_field("m_ip_identification", h.identification, m_ip_identification);
          compare_field("m_ip_ttl", h.ttl, m_ip_ttl);
          compare_field("m_ip_protocol", h.protocol, m_ip_protocol);
          compare_field("m_ip_source_ip", h.source_ip, m_ip_source_ip);
          compare_field("m_ip_dest_ip", h.dest_ip, m_ip_dest_ip);
          compare_field("m_is_roce", h.is_roce, m_is_roce);
        end
      end
      if (m_payload_tvalid && m_payload_tready) begin
        n = 0;
        for (int i = 0; i < 16; i++) begin
          n += int'(m_payload_tkeep[i]);
        end
        // keep must be contiguous from lane 0
        compare_field("m_payload_tkeep", (32'd1 << n) - 32'd1, m_payload_tkeep);
        if (remaining == 0) begin
          assert (exp_len.size() > 0) else begin
            $display("payload beat came out with no frame pending at %0t", $time);
            errors++;
          end
          if (exp_len.size() > 0) begin
            remaining = exp_len.pop_front();
            cur_user  = exp_user.pop_front();
          end
        end
        for (int i = 0; i < n; i++) begin
          assert (exp_bytes.size() > 0) else begin
            $display("more payload bytes came out than were sent at %0t", $time);
            errors++;
          end
          if (exp_bytes.size() > 0) begin
            b = exp_bytes.pop_front();
            compare_field("m_payload_tdata", b, m_payload_tdata[i*8 +: 8]);
          end
        end
        remaining -= n;
        compare_field("m_payload_tlast", remaining <= 0, m_payload_tlast);
        // user only ever marks the final beat of a short frame
        compare_field("m_payload_tuser", (remaining <= 0) && cur_user, m_payload_tuser);
        if (m_payload_tlast) begin
          frame_count++;
          remaining = 0;
        end
      end
    end
  end

endmodule

//--- verilog/pipe_skid_buffer.sv
// ----------------------------------------------------------
// two entry valid/ready buffer, input ready is registered
// upstream may push only while in_ready is high
// ----------------------------------------------------------
`timescale 1ns/10ps

module pipe_skid_buffer #(
  parameter type T = udp_tx_pkg::beat_t
) (
  input  logic clk,
  input  logic rst,
  input  logic in_valid,
  output logic in_ready,
  input  T     in_data,
  output logic out_valid,
  input  logic out_ready,
  output T     out_data
);

  logic out_valid_reg;
  logic temp_valid_reg;
  logic ready_reg;
  logic ready_early;
  T     out_data_reg;
  T     temp_data_reg;

  // room next cycle if the sink drains or both slots are empty
  assign ready_early = out_ready || (!temp_valid_reg && !out_valid_reg);

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_reg  <= 1'b0;
      temp_valid_reg <= 1'b0;
      ready_reg      <= 1'b0;
    end else begin
      ready_reg <= ready_early;
      if (ready_reg) begin
        if (out_ready || !out_valid_reg) begin
          out_valid_reg <= in_valid;
        end else begin
          temp_valid_reg <= in_valid;
        end
      end else if (out_ready) begin
        out_valid_reg  <= temp_valid_reg;
        temp_valid_reg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ready_reg) begin
      if (out_ready || !out_valid_reg) begin
        out_data_reg <= in_data;
      end else begin
        temp_data_reg <= in_data;
      end
    end else if (out_ready) begin
      out_data_reg <= temp_data_reg;
    end
  end

  assign in_ready  = ready_reg;
  assign out_valid = out_valid_reg;
  assign out_data  = out_data_reg;

endmodule

//--- verilog/udp_hdr_regs.sv
// ----------------------------------------------------------
// header capture, one frame in flight at a time
// UDP fields stay stable from frame_start until frame_done
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "udp_tx_defs.svh"

module udp_hdr_regs (
  input  logic                clk,
  input  logic                rst,
  input  logic                s_hdr_valid,
  input  logic [15:0]         s_ip_identification,
  input  logic [7:0]          s_ip_ttl,
  input  logic [7:0]          s_ip_protocol,
  input  udp_tx_pkg::ip_addr_t s_ip_source_ip,
  input  udp_tx_pkg::ip_addr_t s_ip_dest_ip,
  input  udp_tx_pkg::len_t    s_udp_source_port,
  input  udp_tx_pkg::len_t    s_udp_dest_port,
  input  udp_tx_pkg::len_t    s_udp_length,
  input  udp_tx_pkg::len_t    s_udp_checksum,
  output logic                hdr_ready,
  output logic                hdr_push_valid,
  output udp_tx_pkg::ip_hdr_t hdr_push_data,
  input  logic                hdr_push_ready,
  output logic                frame_start,
  input  logic                frame_done,
  output logic                busy,
  output udp_tx_pkg::len_t    udp_source_port,
  output udp_tx_pkg::len_t    udp_dest_port,
  output udp_tx_pkg::len_t    udp_length_field,
  output udp_tx_pkg::len_t    udp_checksum
);
  import udp_tx_pkg::*;

  logic    accept;
  logic    is_roce;
  logic    active_reg;
  logic    pending_reg;
  logic    start_reg;
  ip_hdr_t hdr_reg;
  len_t    src_port_reg;
  len_t    dst_port_reg;
  len_t    length_reg;
  len_t    checksum_reg;

  assign is_roce = (s_udp_dest_port == len_t'(`UDP_TX_ROCE_PORT));

  // no new header while a frame or an unsent header is held
  assign hdr_ready = !active_reg && !pending_reg && hdr_push_ready;
  assign accept    = s_hdr_valid && hdr_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      active_reg  <= 1'b0;
      pending_reg <= 1'b0;
      start_reg   <= 1'b0;
    end else begin
      start_reg <= accept;
      if (accept) begin
        active_reg <= 1'b1;
      end else if (frame_done) begin
        active_reg <= 1'b0;
      end
      // header waits here until the buffer takes it
      if (accept) begin
        pending_reg <= 1'b1;
      end else if (hdr_push_ready) begin
        pending_reg <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      hdr_reg.ip_length      <= s_udp_length + len_t'(`UDP_TX_IP_HDR_BYTES);
      hdr_reg.identification <= s_ip_identification;
      hdr_reg.ttl            <= s_ip_ttl;
      hdr_reg.protocol       <= s_ip_protocol;
      hdr_reg.source_ip      <= s_ip_source_ip;
      hdr_reg.dest_ip        <= s_ip_dest_ip;
      hdr_reg.is_roce        <= is_roce;
      src_port_reg           <= s_udp_source_port;
      dst_port_reg           <= s_udp_dest_port;
      checksum_reg           <= s_udp_checksum;
      // RoCE length covers the ICRC appended downstream
      length_reg <= is_roce ? s_udp_length + len_t'(`UDP_TX_ICRC_BYTES) : s_udp_length;
    end
  end

  assign hdr_push_valid   = pending_reg;
  assign hdr_push_data    = hdr_reg;
  assign frame_start      = start_reg;
  assign busy             = active_reg;
  assign udp_source_port  = src_port_reg;
  assign udp_dest_port    = dst_port_reg;
  assign udp_length_field = length_reg;
  assign udp_checksum     = checksum_reg;

endmodule

//--- verilog/udp_ip_tx.sv
// ----------------------------------------------------------
// UDP to IP transmit framer, one frame in flight per header
// RoCEv2 frames get the ICRC bytes counted in the UDP length
// ----------------------------------------------------------
`timescale 1ns/10ps

module udp_ip_tx (
  input  logic                 clk,
  input  logic                 rst,
  // header in
  input  logic                 s_hdr_valid,
  output logic                 s_hdr_ready,
  input  logic [15:0]          s_ip_identification,
  input  logic [7:0]           s_ip_ttl,
  input  logic [7:0]           s_ip_protocol,
  input  udp_tx_pkg::ip_addr_t s_ip_source_ip,
  input  udp_tx_pkg::ip_addr_t s_ip_dest_ip,
  input  udp_tx_pkg::len_t     s_udp_source_port,
  input  udp_tx_pkg::len_t     s_udp_dest_port,
  input  udp_tx_pkg::len_t     s_udp_length,
  input  udp_tx_pkg::len_t     s_udp_checksum,
  // payload in
  input  udp_tx_pkg::data_t    s_payload_tdata,
  input  udp_tx_pkg::keep_t    s_payload_tkeep,
  input  logic                 s_payload_tvalid,
  output logic                 s_payload_tready,
  input  logic                 s_payload_tlast,
  input  logic                 s_payload_tuser,
  // header out
  output logic                 m_hdr_valid,
  input  logic                 m_hdr_ready,
  output udp_tx_pkg::len_t     m_ip_length,
  output logic [15:0]          m_ip_identification,
  output logic [7:0]           m_ip_ttl,
  output logic [7:0]           m_ip_protocol,
  output udp_tx_pkg::ip_addr_t m_ip_source_ip,
  output udp_tx_pkg::ip_addr_t m_ip_dest_ip,
  output logic                 m_is_roce,
  // payload out
  output udp_tx_pkg::data_t    m_payload_tdata,
  output udp_tx_pkg::keep_t    m_payload_tkeep,
  output logic                 m_payload_tvalid,
  input  logic                 m_payload_tready,
  output logic                 m_payload_tlast,
  output logic                 m_payload_tuser,
  // status
  output logic                 busy,
  output logic                 error_early_term
);
  import udp_tx_pkg::*;

  logic    frame_start;
  logic    frame_done;
  len_t    udp_source_port;
  len_t    udp_dest_port;
  len_t    udp_length_field;
  len_t    udp_checksum;
  logic    hdr_push_valid;
  logic    hdr_push_ready;
  ip_hdr_t hdr_push_data;
  ip_hdr_t hdr_out;
  logic    pay_push_valid;
  logic    pay_push_ready;
  beat_t   pay_push_beat;
  beat_t   pay_out;

  udp_hdr_regs hdr_regs0 (
    .clk                 (clk),
    .rst                 (rst),
    .s_hdr_valid         (s_hdr_valid),
    .s_ip_identification (s_ip_identification),
    .s_ip_ttl            (s_ip_ttl),
    .s_ip_protocol       (s_ip_protocol),
    .s_ip_source_ip      (s_ip_source_ip),
    .s_ip_dest_ip        (s_ip_dest_ip),
    .s_udp_source_port   (s_udp_source_port),
    .s_udp_dest_port     (s_udp_dest_port),
    .s_udp_length        (s_udp_length),
    .s_udp_checksum      (s_udp_checksum),
    .hdr_ready           (s_hdr_ready),
    .hdr_push_valid      (hdr_push_valid),
    .hdr_push_data       (hdr_push_data),
    .hdr_push_ready      (hdr_push_ready),
    .frame_start         (frame_start),
    .frame_done          (frame_done),
    .busy                (busy),
    .udp_source_port     (udp_source_port),
    .udp_dest_port       (udp_dest_port),
    .udp_length_field    (udp_length_field),
    .udp_checksum        (udp_checksum)
  );

  udp_payload_framer framer0 (
    .clk              (clk),
    .rst              (rst),
    .frame_start      (frame_start),
    .frame_done       (frame_done),
    .udp_source_port  (udp_source_port),
    .udp_dest_port    (udp_dest_port),
    .udp_length_field (udp_length_field),
    .udp_checksum     (udp_checksum),
    .s_tdata          (s_payload_tdata),
    .s_tkeep          (s_payload_tkeep),
    .s_tvalid         (s_payload_tvalid),
    .s_tready         (s_payload_tready),
    .s_tlast          (s_payload_tlast),
    .s_tuser          (s_payload_tuser),
    .out_valid        (pay_push_valid),
    .out_beat         (pay_push_beat),
    .out_ready        (pay_push_ready),
    .error_early_term (error_early_term)
  );

  pipe_skid_buffer #(.T(ip_hdr_t)) hdr_buf0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (hdr_push_valid),
    .in_ready  (hdr_push_ready),
    .in_data   (hdr_push_data),
    .out_valid (m_hdr_valid),
    .out_ready (m_hdr_ready),
    .out_data  (hdr_out)
  );

  pipe_skid_buffer #(.T(beat_t)) pay_buf0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (pay_push_valid),
    .in_ready  (pay_push_ready),
    .in_data   (pay_push_beat),
    .out_valid (m_payload_tvalid),
    .out_ready (m_payload_tready),
    .out_data  (pay_out)
  );

  // buffered structs onto the loose output ports
  assign m_ip_length         = hdr_out.ip_length;
  assign m_ip_identification = hdr_out.identification;
  assign m_ip_ttl            = hdr_out.ttl;
  assign m_ip_protocol       = hdr_out.protocol;
  assign m_ip_source_ip      = hdr_out.source_ip;
  assign m_ip_dest_ip        = hdr_out.dest_ip;
  assign m_is_roce           = hdr_out.is_roce;

  assign m_payload_tdata = pay_out.data;
  assign m_payload_tkeep = pay_out.keep;
  assign m_payload_tlast = pay_out.last;
  assign m_payload_tuser = pay_out.user;

endmodule

//--- verilog/udp_payload_framer.sv
// ----------------------------------------------------------
// puts the UDP header ahead of the payload and shifts by 8 bytes
// input keep must be contiguous from byte 0; long frames pass whole
// ----------------------------------------------------------
`timescale 1ns/10ps
`include "udp_tx_defs.svh"

module udp_payload_framer (
  input  logic              clk,
  input  logic              rst,
  input  logic              frame_start,
  output logic              frame_done,
  input  udp_tx_pkg::len_t  udp_source_port,
  input  udp_tx_pkg::len_t  udp_dest_port,
  input  udp_tx_pkg::len_t  udp_length_field,
  input  udp_tx_pkg::len_t  udp_checksum,
  input  udp_tx_pkg::data_t s_tdata,
  input  udp_tx_pkg::keep_t s_tkeep,
  input  logic              s_tvalid,
  output logic              s_tready,
  input  logic              s_tlast,
  input  logic              s_tuser,
  output logic              out_valid,
  output udp_tx_pkg::beat_t out_beat,
  input  logic              out_ready,
  output logic              error_early_term
);
  import udp_tx_pkg::*;

  localparam int BYTES = `UDP_TX_DATA_BYTES;
  localparam int HB    = `UDP_TX_UDP_HDR_BYTES;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_FIRST,
    ST_PAYLOAD,
    ST_FLUSH
  } state_t;

  state_t              state_reg;
  state_t              state_next;
  len_t                owed_reg;
  len_t                owed_next;
  len_t                payload_len;
  len_t                in_count;
  logic                in_xfer;
  logic                early;
  logic                need_flush;
  logic                err_reg;
  logic [HB*8-1:0]     hdr_bytes;
  logic [HB*8-1:0]     save_data_reg;
  logic [HB-1:0]       save_keep_reg;
  logic                save_user_reg;

  // contiguous keep, so a plain count gives the byte total
  function automatic len_t keep_count(input keep_t k);
    len_t n;
    n = '0;
    for (int i = 0; i < BYTES; i++) begin
      n = n + len_t'(k[i]);
    end
    return n;
  endfunction

  // payload bytes owed, without header and without the RoCE ICRC
  assign payload_len = udp_length_field - len_t'(HB) -
                       ((udp_dest_port == len_t'(`UDP_TX_ROCE_PORT)) ?
                        len_t'(`UDP_TX_ICRC_BYTES) : len_t'(0));

  // network byte order, byte 0 in the low lane
  assign hdr_bytes = {udp_checksum[7:0], udp_checksum[15:8],
                      udp_length_field[7:0], udp_length_field[15:8],
                      udp_dest_port[7:0], udp_dest_port[15:8],
                      udp_source_port[7:0], udp_source_port[15:8]};

  assign s_tready   = (state_reg == ST_FIRST || state_reg == ST_PAYLOAD) && out_ready;
  assign in_xfer    = s_tvalid && s_tready;
  assign in_count   = keep_count(s_tkeep);
  assign early      = s_tlast && (in_count < owed_reg);
  // upper half of the last beat spills into one more output beat
  assign need_flush = s_tlast && (s_tkeep[BYTES-1:HB] != '0);

  always_comb begin
    state_next = state_reg;
    owed_next  = owed_reg;
    out_valid  = 1'b0;
    out_beat   = '0;
    frame_done = 1'b0;

    case (state_reg)
      ST_IDLE: begin
        if (frame_start) begin
          owed_next  = payload_len;
          state_next = ST_FIRST;
        end
      end
      ST_FIRST, ST_PAYLOAD: begin
        if (state_reg == ST_FIRST) begin
          out_beat.data = {s_tdata[HB*8-1:0], hdr_bytes};
          out_beat.keep = {s_tkeep[HB-1:0], {HB{1'b1}}};
        end else begin
          out_beat.data = {s_tdata[HB*8-1:0], save_data_reg};
          out_beat.keep = {s_tkeep[HB-1:0], save_keep_reg};
        end
        out_beat.last = s_tlast && !need_flush;
        out_beat.user = s_tlast && !need_flush && (s_tuser || early);
        out_valid     = in_xfer;
        if (in_xfer) begin
          owed_next = (in_count >= owed_reg) ? len_t'(0) : owed_reg - in_count;
          if (!s_tlast) begin
            state_next = ST_PAYLOAD;
          end else if (need_flush) begin
            state_next = ST_FLUSH;
          end else begin
            frame_done = 1'b1;
            state_next = ST_IDLE;
          end
        end
      end
      ST_FLUSH: begin
        out_beat.data = {{(BYTES - HB)*8{1'b0}}, save_data_reg};
        out_beat.keep = {{(BYTES - HB){1'b0}}, save_keep_reg};
        out_beat.last = 1'b1;
        out_beat.user = save_user_reg;
        out_valid     = 1'b1;
        if (out_ready) begin
          frame_done = 1'b1;
          state_next = ST_IDLE;
        end
      end
      default: begin
        state_next = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg <= ST_IDLE;
      owed_reg  <= '0;
      err_reg   <= 1'b0;
    end else begin
      state_reg <= state_next;
      owed_reg  <= owed_next;
      err_reg   <= in_xfer && early;
    end
  end

  // upper half of each consumed beat goes out with the next one
  always_ff @(posedge clk) begin
    if (in_xfer) begin
      save_data_reg <= s_tdata[BYTES*8-1:HB*8];
      save_keep_reg <= s_tkeep[BYTES-1:HB];
      save_user_reg <= s_tuser || early;
    end
  end

  assign error_early_term = err_reg;

endmodule

//--- verilog/udp_tx_pkg.sv
// ----------------------------------------------------------
// datapath and header types shared by the UDP transmit blocks
// ----------------------------------------------------------
`include "udp_tx_defs.svh"

package udp_tx_pkg;

  typedef logic [`UDP_TX_DATA_BYTES*8-1:0] data_t;
  typedef logic [`UDP_TX_DATA_BYTES-1:0]   keep_t;
  typedef logic [15:0]                     len_t;
  typedef logic [31:0]                     ip_addr_t;

  // one payload beat, byte 0 in the low lane
  typedef struct packed {
    data_t data;
    keep_t keep;
    logic  last;
    logic  user;
  } beat_t;

  // emitted IP header, only the fields this block produces
  typedef struct packed {
    len_t        ip_length;
    len_t        identification;
    logic [7:0]  ttl;
    logic [7:0]  protocol;
    ip_addr_t    source_ip;
    ip_addr_t    dest_ip;
    logic        is_roce;
  } ip_hdr_t;

endpackage
